//--- logic/cache_pkg.sv
// cache geometry constants, derived field widths and the controller state type
`default_nettype none

package cache_pkg;

    // word address and data widths
    localparam int ADDR_W = 12;
    localparam int DATA_W = 16;
    localparam int BYTES = DATA_W / 8;

    // direct-mapped geometry
    localparam int LINES = 64;
    localparam int LINE_WORDS = 8;

    // address fields, tag | index | offset
    localparam int OFFSET_BITS = $clog2(LINE_WORDS);
    localparam int INDEX_BITS = $clog2(LINES);
    localparam int TAG_BITS = ADDR_W - INDEX_BITS - OFFSET_BITS;
    localparam int LINE_ADDR_W = INDEX_BITS + OFFSET_BITS;

    // backing memory
    localparam int MEM_WORDS = 1 << ADDR_W;
    localparam int MEM_WAIT = 2;
    localparam int MEM_WAIT_W = $clog2(MEM_WAIT + 1);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FLUSH,
        FILL
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/mem_bus_if.sv
// word-wide backend bus between the cache controller and the SRAM port
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if
    import cache_pkg::*;
(
    input logic clk
);

    // master side, access is a level held until ack
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic access;
    logic wr_en;
    logic [BYTES-1:0] bytesel;

    // slave side, ack is a single-cycle pulse
    logic [DATA_W-1:0] rdata;
    logic ack;

    modport master (
        input clk,
        output addr, wdata, access, wr_en, bytesel,
        input rdata, ack
    );

    modport slave (
        input clk,
        input addr, wdata, access, wr_en, bytesel,
        output rdata, ack
    );

endinterface

`default_nettype wire

//--- logic/cache_tag_store.sv
// per-line tag, valid and dirty storage with a registered lookup port and an update port
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store
    import cache_pkg::*;
(
    input logic clk,
    input logic reset,
    // lookup port
    input logic [INDEX_BITS-1:0] lookup_index,
    output logic [TAG_BITS-1:0] tag,
    output logic valid,
    output logic dirty,
    // update port
    input logic [INDEX_BITS-1:0] upd_index,
    input logic [TAG_BITS-1:0] upd_tag,
    input logic tag_we,
    input logic valid_we,
    input logic valid_val,
    input logic dirty_we,
    input logic dirty_val
);

    logic [TAG_BITS-1:0] tag_arr [LINES];
    logic dirty_arr [LINES];
    // flop vector so the whole array clears in one reset
    logic [LINES-1:0] valid_arr;

    // tag and dirty arrays, read is registered
    always_ff @(posedge clk) begin
        tag <= tag_arr[lookup_index];
        dirty <= dirty_arr[lookup_index];
        if (tag_we) begin
            tag_arr[upd_index] <= upd_tag;
        end
        if (dirty_we) begin
            dirty_arr[upd_index] <= dirty_val;
        end
    end

    // valid bits, cleared so no line hits after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_arr <= '0;
            valid <= 1'b0;
        end else begin
            // old value is returned when reading the line being updated
            valid <= valid_arr[lookup_index];
            if (valid_we) begin
                valid_arr[upd_index] <= valid_val;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/cache_line_store.sv
// dual-port cache data array, byte-lane writes on port A and whole-word writes on port B
`timescale 1ns/1ps
`default_nettype none

module cache_line_store
    import cache_pkg::*;
(
    input logic clk,
    // port A, frontend side
    input logic [LINE_ADDR_W-1:0] a_addr,
    input logic a_we,
    input logic [BYTES-1:0] a_be,
    input logic [DATA_W-1:0] a_wdata,
    output logic [DATA_W-1:0] a_rdata,
    // port B, flush and fill side
    input logic [LINE_ADDR_W-1:0] b_addr,
    input logic b_we,
    input logic [DATA_W-1:0] b_wdata,
    output logic [DATA_W-1:0] b_rdata
);

    // index in the upper bits, word offset in the lower bits
    logic [DATA_W-1:0] line_mem [LINES * LINE_WORDS];

    always_ff @(posedge clk) begin
        // port A merges only the selected byte lanes
        if (a_we) begin
            for (int i = 0; i < BYTES; i++) begin
                if (a_be[i]) begin
                    line_mem[a_addr][8*i +: 8] <= a_wdata[8*i +: 8];
                end
            end
        end
        // port B always writes the full word from memory
        if (b_we) begin
            line_mem[b_addr] <= b_wdata;
        end
        // both reads are registered, old data on a same-cycle write
        a_rdata <= line_mem[a_addr];
        b_rdata <= line_mem[b_addr];
    end

endmodule

`default_nettype wire

//--- logic/cache_ctrl.sv
// cache controller: hit/miss decision, flush and fill sequencing, bypass routing
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic enabled,
    // frontend
    input logic [ADDR_W-1:0] c_addr,
    input logic [DATA_W-1:0] c_wdata,
    output logic [DATA_W-1:0] c_rdata,
    input logic c_access,
    output logic c_ack,
    input logic c_wr_en,
    input logic [BYTES-1:0] c_bytesel,
    // tag store
    input logic [TAG_BITS-1:0] tag,
    input logic valid,
    input logic dirty,
    output logic [INDEX_BITS-1:0] lookup_index,
    output logic [INDEX_BITS-1:0] upd_index,
    output logic [TAG_BITS-1:0] upd_tag,
    output logic tag_we,
    output logic valid_we,
    output logic valid_val,
    output logic dirty_we,
    output logic dirty_val,
    // line store
    input logic [DATA_W-1:0] a_rdata,
    input logic [DATA_W-1:0] b_rdata,
    output logic [LINE_ADDR_W-1:0] a_addr,
    output logic a_we,
    output logic [BYTES-1:0] a_be,
    output logic [LINE_ADDR_W-1:0] b_addr,
    output logic b_we,
    // backend
    mem_bus_if.master mem
);

    ctrl_state_t state;
    logic [ADDR_W-1:0] req_addr;
    logic req_we;
    logic [TAG_BITS-1:0] victim_tag;
    logic [OFFSET_BITS-1:0] ptr;
    logic [LINE_WORDS-1:0] arrived;
    logic ack_q;
    logic acked;

    logic [OFFSET_BITS-1:0] req_off;
    logic [INDEX_BITS-1:0] req_index;
    logic [TAG_BITS-1:0] req_tag;
    logic hit;
    logic last_word;
    logic early_ack;
    logic [OFFSET_BITS-1:0] b_ptr;

    assign req_off = req_addr[OFFSET_BITS-1:0];
    assign req_index = req_addr[OFFSET_BITS +: INDEX_BITS];
    assign req_tag = req_addr[ADDR_W-1 -: TAG_BITS];

    // a completed fill counts as a hit while the tag store catches up
    assign hit = (valid && tag == req_tag) || (&arrived);
    assign last_word = mem.ack && (&ptr);
    // read may finish once its word sits in the line
    assign early_ack = (state == FILL) && !req_we && !acked && arrived[req_off];

    // lookups use the live address until the request is latched
    assign lookup_index = (state == IDLE) ? c_addr[OFFSET_BITS +: INDEX_BITS] : req_index;
    assign a_addr = (state == IDLE) ? c_addr[LINE_ADDR_W-1:0] : req_addr[LINE_ADDR_W-1:0];
    assign a_we = (state == LOOKUP) && hit && req_we;
    assign a_be = c_bytesel;

    // prefetch the next flush word in the ack cycle
    assign b_ptr = (state == FLUSH && mem.ack) ? ptr + 1'b1 : ptr;
    assign b_addr = {req_index, b_ptr};
    assign b_we = (state == FILL) && mem.ack;

    // tag store updates always target the requested line
    assign upd_index = req_index;
    assign upd_tag = req_tag;
    assign tag_we = ((state == LOOKUP) && !hit && !(valid && dirty)) ||
                    ((state == FLUSH) && last_word);
    assign valid_we = ((state == LOOKUP) && !hit) || ((state == FILL) && last_word);
    assign valid_val = (state == FILL);
    // write hit sets dirty, any miss clears it
    assign dirty_we = (state == LOOKUP) && (!hit || req_we);
    assign dirty_val = hit;

    // frontend sees the cache or the raw bus
    assign c_rdata = enabled ? a_rdata : mem.rdata;
    assign c_ack = enabled ? ack_q : mem.ack;

    // backend is owned by the sequencer when enabled
    assign mem.access = enabled ? (state == FLUSH || state == FILL) : c_access;
    assign mem.wr_en = enabled ? (state == FLUSH) : c_wr_en;
    assign mem.bytesel = enabled ? {BYTES{1'b1}} : c_bytesel;
    assign mem.wdata = enabled ? b_rdata : c_wdata;
    assign mem.addr = enabled ?
                      {(state == FLUSH) ? victim_tag : req_tag, req_index, ptr} : c_addr;

    // request and victim capture
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            req_addr <= c_addr;
            req_we <= c_wr_en;
        end
        if (state == LOOKUP) begin
            victim_tag <= tag;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            ptr <= '0;
            arrived <= '0;
            ack_q <= 1'b0;
            acked <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            // word pointer wraps back to zero after eight transfers
            if ((state == FLUSH || state == FILL) && mem.ack) begin
                ptr <= ptr + 1'b1;
            end
            case (state)
                IDLE: begin
                    // ack_q guard stops the held request being taken twice
                    if (enabled && c_access && !ack_q) begin
                        state <= LOOKUP;
                        arrived <= '0;
                        acked <= 1'b0;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        ack_q <= 1'b1;
                        state <= IDLE;
                    end else if (valid && dirty) begin
                        state <= FLUSH;
                    end else begin
                        state <= FILL;
                    end
                end
                FLUSH: begin
                    if (last_word) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    if (mem.ack) begin
                        arrived[ptr] <= 1'b1;
                    end
                    if (early_ack) begin
                        ack_q <= 1'b1;
                        acked <= 1'b1;
                    end
                    // writes and late reads finish through LOOKUP
                    if (last_word) begin
                        state <= (acked || early_ack) ? IDLE : LOOKUP;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/sram_port.sv
// word memory model with fixed wait states and a one-cycle ack per access
`timescale 1ns/1ps
`default_nettype none

module sram_port
    import cache_pkg::*;
(
    input logic clk,
    input logic reset,
    mem_bus_if.slave mem
);

    logic [DATA_W-1:0] sram_mem [MEM_WORDS];
    logic [MEM_WAIT_W-1:0] wait_cnt;

    // wait counter, restarts after every ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
            mem.ack <= 1'b0;
        end else begin
            mem.ack <= 1'b0;
            if (mem.access && !mem.ack) begin
                if (wait_cnt == MEM_WAIT_W'(MEM_WAIT - 1)) begin
                    // ack lands MEM_WAIT+1 cycles into the access
                    mem.ack <= 1'b1;
                    wait_cnt <= '0;
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end else begin
                // idle or ack cycle
                wait_cnt <= '0;
            end
        end
    end

    // array access, address is stable for the whole transfer
    always_ff @(posedge clk) begin
        mem.rdata <= sram_mem[mem.addr];
        // writes commit at the end of the ack cycle
        if (mem.access && mem.ack && mem.wr_en) begin
            for (int i = 0; i < BYTES; i++) begin
                if (mem.bytesel[i]) begin
                    sram_mem[mem.addr][8*i +: 8] <= mem.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/cache_subsystem.sv
// top level: cache controller, tag and line stores, backend bus and SRAM port
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem
    import cache_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic enabled,
    input logic [ADDR_W-1:0] c_addr,
    input logic [DATA_W-1:0] c_wdata,
    output logic [DATA_W-1:0] c_rdata,
    input logic c_access,
    output logic c_ack,
    input logic c_wr_en,
    input logic [BYTES-1:0] c_bytesel
);

    // tag store lookup and update
    logic [TAG_BITS-1:0] tag;
    logic valid;
    logic dirty;
    logic [INDEX_BITS-1:0] lookup_index;
    logic [INDEX_BITS-1:0] upd_index;
    logic [TAG_BITS-1:0] upd_tag;
    logic tag_we;
    logic valid_we;
    logic valid_val;
    logic dirty_we;
    logic dirty_val;

    // line store ports
    logic [LINE_ADDR_W-1:0] a_addr;
    logic a_we;
    logic [BYTES-1:0] a_be;
    logic [DATA_W-1:0] a_rdata;
    logic [LINE_ADDR_W-1:0] b_addr;
    logic b_we;
    logic [DATA_W-1:0] b_rdata;

    mem_bus_if i_mem_bus (.clk(clk));

    cache_ctrl i_cache_ctrl (
        .clk(clk), .reset(reset), .enabled(enabled),
        .c_addr(c_addr), .c_wdata(c_wdata), .c_rdata(c_rdata),
        .c_access(c_access), .c_ack(c_ack), .c_wr_en(c_wr_en), .c_bytesel(c_bytesel),
        .tag(tag), .valid(valid), .dirty(dirty), .lookup_index(lookup_index),
        .upd_index(upd_index), .upd_tag(upd_tag), .tag_we(tag_we),
        .valid_we(valid_we), .valid_val(valid_val),
        .dirty_we(dirty_we), .dirty_val(dirty_val),
        .a_rdata(a_rdata), .b_rdata(b_rdata), .a_addr(a_addr), .a_we(a_we),
        .a_be(a_be), .b_addr(b_addr), .b_we(b_we),
        .mem(i_mem_bus)
    );

    cache_tag_store i_cache_tag_store (
        .clk(clk), .reset(reset), .lookup_index(lookup_index),
        .tag(tag), .valid(valid), .dirty(dirty),
        .upd_index(upd_index), .upd_tag(upd_tag), .tag_we(tag_we),
        .valid_we(valid_we), .valid_val(valid_val),
        .dirty_we(dirty_we), .dirty_val(dirty_val)
    );

    // fill data comes straight off the backend bus
    cache_line_store i_cache_line_store (
        .clk(clk),
        .a_addr(a_addr), .a_we(a_we), .a_be(a_be), .a_wdata(c_wdata), .a_rdata(a_rdata),
        .b_addr(b_addr), .b_we(b_we), .b_wdata(i_mem_bus.rdata), .b_rdata(b_rdata)
    );

    sram_port i_sram_port (
        .clk(clk),
        .reset(reset),
        .mem(i_mem_bus)
    );

endmodule

`default_nettype wire

//--- sim/cache_subsystem_sva.sv
// bound assertions on the frontend ack and the backend bus handshake of the cache controller
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem_sva
    import cache_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic enabled,
    input ctrl_state_t state,
    input logic valid,
    input logic dirty,
    input logic c_ack,
    input logic mem_access,
    input logic mem_ack,
    input logic mem_wr_en,
    input logic [ADDR_W-1:0] mem_addr
);

    // frontend ack lasts one cycle
    ack_pulse: assert property (@(posedge clk) disable iff (reset) c_ack |=> !c_ack)
        else $error("c_ack high for more than one cycle");

    // a pending transfer keeps access and address until ack
    access_hold: assert property (@(posedge clk) disable iff (reset)
        mem_access && !mem_ack |=> mem_access && $stable(mem_addr))
        else $error("backend access dropped or address moved before ack");

    // cached write-back only starts right after a lookup found a valid dirty line
    write_in_flush: assert property (@(posedge clk) disable iff (reset)
        enabled && $rose(mem_wr_en) |-> $past(state) == LOOKUP && $past(valid && dirty))
        else $error("backend write not started by a dirty lookup");

    ack_in_reset: assert property (@(posedge clk) reset |-> !c_ack)
        else $error("c_ack high during reset");

endmodule

bind cache_ctrl cache_subsystem_sva i_cache_subsystem_sva (
    .clk(clk), .reset(reset), .enabled(enabled), .state(state),
    .valid(valid), .dirty(dirty), .c_ack(c_ack),
    .mem_access(mem.access), .mem_ack(mem.ack), .mem_wr_en(mem.wr_en),
    .mem_addr(mem.addr)
);

`default_nettype wire

//--- sim/cache_subsystem_tb.sv
// testbench for the cache subsystem with clock, reset, stimulus table, memory model, checks and timeout
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem_tb
    import cache_pkg::*;
();

    // one backend transfer, and the worst case per row is a dirty miss
    localparam int XFER_CYCLES = MEM_WAIT + 1;
    localparam int MAX_ROWS = 96;
    localparam int ROW_LIMIT = 2 * (2 * LINE_WORDS) * XFER_CYCLES + 16;
    localparam int SETTLE_CYCLES = LINE_WORDS * XFER_CYCLES + 4;
    localparam int TIMEOUT_CYCLES = MAX_ROWS * (2 * LINE_WORDS * XFER_CYCLES + 4) + 400;

    logic clk = 1'b0;
    logic reset;
    logic enabled;
    logic [ADDR_W-1:0] c_addr;
    logic [DATA_W-1:0] c_wdata;
    logic [DATA_W-1:0] c_rdata;
    logic c_access;
    logic c_ack;
    logic c_wr_en;
    logic [BYTES-1:0] c_bytesel;

    // stimulus table, one row per frontend operation
    logic row_mode [MAX_ROWS];
    logic row_wr [MAX_ROWS];
    logic [ADDR_W-1:0] row_addr [MAX_ROWS];
    logic [DATA_W-1:0] row_wdata [MAX_ROWS];
    logic [BYTES-1:0] row_be [MAX_ROWS];
    logic [DATA_W-1:0] row_exp [MAX_ROWS];
    // expected ack latency in cycles, 0 when not checked
    int row_lat [MAX_ROWS];
    int num_rows = 0;

    // reference memory, the value the requester should see at each address
    logic [DATA_W-1:0] model_mem [MEM_WORDS];
    int seed = 61;
    int errors = 0;
    int checks = 0;
    int cycle_cnt = 0;

    always #10 clk = ~clk;

    cache_subsystem i_cache_subsystem (
        .clk(clk), .reset(reset), .enabled(enabled),
        .c_addr(c_addr), .c_wdata(c_wdata), .c_rdata(c_rdata),
        .c_access(c_access), .c_ack(c_ack), .c_wr_en(c_wr_en), .c_bytesel(c_bytesel)
    );

    // run limit from the worst-case row length
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // word after a write that only touches the selected byte lanes
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
            input logic [DATA_W-1:0] new_word, input logic [BYTES-1:0] be);
        logic [DATA_W-1:0] result;
        result = old_word;
        for (int i = 0; i < BYTES; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    // preload pattern, every address bit shows up in the word
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return {addr[3:0] ^ 4'h9, addr};
    endfunction

    // word address from tag, line index and offset
    function automatic logic [ADDR_W-1:0] window_addr(input int t, input int idx, input int off);
        return ADDR_W'((t << (INDEX_BITS + OFFSET_BITS)) | (idx << OFFSET_BITS) | off);
    endfunction

    task automatic add_row(input logic mode, input logic wr, input logic [ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] wdata, input logic [BYTES-1:0] be, input int lat);
        row_mode[num_rows] = mode;
        row_wr[num_rows] = wr;
        row_addr[num_rows] = addr;
        row_wdata[num_rows] = wdata;
        row_be[num_rows] = be;
        row_lat[num_rows] = lat;
        // writes update the model, reads take their expected value from it
        if (wr) begin
            model_mem[addr] = merge_bytes(model_mem[addr], wdata, be);
            row_exp[num_rows] = '0;
        end else begin
            row_exp[num_rows] = model_mem[addr];
        end
        num_rows++;
    endtask

    task automatic build_table();
        logic [ADDR_W-1:0] a;
        int i;
        int r;
        // bypass preload of two tags times two lines, then sparse read back
        for (i = 0; i < 4 * LINE_WORDS; i++) begin
            a = window_addr(i / 16, (i / 8) % 2, i % 8);
            add_row(1'b0, 1'b1, a, fill_word(a), 2'b11, 0);
        end
        for (i = 3; i < 4 * LINE_WORDS; i += 4) begin
            add_row(1'b0, 1'b0, window_addr(i / 16, (i / 8) % 2, i % 8), '0, 2'b11, 0);
        end
        // clean read miss, then a hit on the same line with fixed latency
        add_row(1'b1, 1'b0, window_addr(0, 1, 2), '0, 2'b11, 0);
        add_row(1'b1, 1'b0, window_addr(0, 1, 5), '0, 2'b11, 2);
        // byte merges into line 0
        add_row(1'b1, 1'b1, window_addr(0, 0, 3), 16'hc3a1, 2'b01, 0);
        add_row(1'b1, 1'b1, window_addr(0, 0, 3), 16'h7e5c, 2'b10, 0);
        add_row(1'b1, 1'b1, window_addr(0, 0, 4), 16'hb00f, 2'b11, 0);
        add_row(1'b1, 1'b0, window_addr(0, 0, 3), '0, 2'b11, 0);
        add_row(1'b1, 1'b0, window_addr(0, 0, 4), '0, 2'b11, 0);
        // conflicting tag evicts the dirty line, memory must hold the merged words
        add_row(1'b1, 1'b0, window_addr(1, 0, 6), '0, 2'b11, 0);
        add_row(1'b0, 1'b0, window_addr(0, 0, 3), '0, 2'b11, 0);
        add_row(1'b0, 1'b0, window_addr(0, 0, 4), '0, 2'b11, 0);
        // random traffic over the window, two tags per index
        for (i = 0; i < 40; i++) begin
            r = $random(seed);
            add_row(1'b1, r[0], window_addr(r[1], r[2], r[5:3]), r[31:16],
                    (r[7:6] == 2'b00) ? 2'b11 : r[7:6], 0);
        end
    endtask

    task automatic compare(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic run_row(input int r);
        int cycles;
        int errs_before;
        logic got_ack;
        errs_before = errors;
        // mode switches and timed rows wait until any fill has drained
        if (row_mode[r] != enabled || row_lat[r] != 0) begin
            repeat (SETTLE_CYCLES) @(negedge clk);
        end
        @(negedge clk);
        enabled = row_mode[r];
        c_addr = row_addr[r];
        c_wdata = row_wdata[r];
        c_wr_en = row_wr[r];
        c_bytesel = row_be[r];
        c_access = 1'b1;
        cycles = 0;
        got_ack = 1'b0;
        while (!got_ack && cycles < ROW_LIMIT) begin
            @(negedge clk);
            cycles++;
            got_ack = c_ack;
        end
        if (!got_ack) begin
            errors++;
            $display("row %0d: no ack from the cache within %0d cycles", r, ROW_LIMIT);
        end else begin
            if (!row_wr[r]) begin
                compare("c_rdata", c_rdata, row_exp[r]);
            end
            if (row_lat[r] != 0) begin
                compare("c_ack latency", cycles, row_lat[r]);
            end
        end
        // hold through the ack cycle so a bypass write commits
        @(negedge clk);
        c_access = 1'b0;
        $display("row %0d %s %s addr %h: %s", r, row_mode[r] ? "cached" : "bypass",
                 row_wr[r] ? "write" : "read", row_addr[r],
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int r;
        reset = 1'b1;
        enabled = 1'b0;
        c_addr = '0;
        c_wdata = '0;
        c_access = 1'b0;
        c_wr_en = 1'b0;
        c_bytesel = '0;
        build_table();
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        repeat (4) @(negedge clk);
        $display("rows %0d, checks %0d, errors %0d", num_rows, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
logic/cache_pkg.sv
logic/mem_bus_if.sv
logic/cache_tag_store.sv
logic/cache_line_store.sv
logic/cache_ctrl.sv
logic/sram_port.sv
logic/cache_subsystem.sv
sim/cache_subsystem_sva.sv
sim/cache_subsystem_tb.sv
